/* design/hsem_pkg.sv */
// shared widths, core ids, register map and enums for the semaphore block, referenced by scope
package hsem_pkg;

    // -------------------- bus and field widths
    localparam int DATA_W    = 32;
    localparam int ADDR_W    = 8;
    localparam int SEM_NUM   = 8;
    localparam int SEMIDX_W  = $clog2(SEM_NUM);   // index of one semaphore
    localparam int SEMNUM_W  = 5;                 // semaphore number field of the error reg
    localparam int ID_W      = 8;

    // core ids as written in the owner field
    localparam logic [ID_W-1:0] CORE_0_ID = 8'h01;
    localparam logic [ID_W-1:0] CORE_1_ID = 8'h02;

    // data word layout of a semaphore access
    localparam int TAKEN_BIT = 0;    // lock request on write, taken flag on read
    localparam int OWNER_LSB = 8;
    localparam int OWNER_MSB = 15;

    // -------------------- register offsets
    localparam logic [ADDR_W-1:0] SEM_BASE        = 8'h00;
    localparam int                SEM_STRIDE      = 4;     // one word per semaphore
    localparam logic [ADDR_W-1:0] ERR_OFFSET      = 8'h28;
    localparam logic [ADDR_W-1:0] ERR_CLR_OFFSET  = 8'h2C;
    localparam logic [ADDR_W-1:0] STATUS_0_OFFSET = 8'h30;
    localparam logic [ADDR_W-1:0] STATUS_1_OFFSET = 8'h34;

    // error reg is {valid, faultid, semnum, code}
    localparam int ERR_VALID_BIT = 16;

    typedef enum logic [2:0] {
        ERR_ALREADY_FREE = 3'd0,
        ERR_ILLEGAL_FREE = 3'd1,
        ERR_ALREADY_OWN  = 3'd3,
        ERR_NONE         = 3'd7
    } sem_err_e;

    typedef enum logic {
        SEM_FREE  = 1'b0,
        SEM_TAKEN = 1'b1
    } sem_state_e;

    typedef enum logic [2:0] {
        RD_SEM,
        RD_ERR,
        RD_STATUS_0,
        RD_STATUS_1,
        RD_NONE
    } read_sel_e;

endpackage

/* design/sem_addr_decode.sv */
// address decoder, turns addr and wr_en into per-semaphore write strobes and a read select
module sem_addr_decode
(
    input  logic [hsem_pkg::ADDR_W-1:0]   addr,
    input  logic                          wr_en,
    output logic [hsem_pkg::SEM_NUM-1:0]  sem_wr,
    output logic                          err_clr,
    output hsem_pkg::read_sel_e           rd_sel,
    output logic [hsem_pkg::SEMIDX_W-1:0] rd_idx
);

    logic [hsem_pkg::ADDR_W-1:0] sem_off;   // address relative to the semaphore window
    logic                        sem_hit;

    // --------------------
    // semaphore window
    // --------------------
    assign sem_off = addr - hsem_pkg::SEM_BASE;
    assign sem_hit = (addr >= hsem_pkg::SEM_BASE) &&
                     (sem_off < hsem_pkg::ADDR_W'(hsem_pkg::SEM_STRIDE * hsem_pkg::SEM_NUM)) &&
                     (sem_off[1:0] == 2'b00);   // word aligned only
    assign rd_idx  = sem_off[hsem_pkg::SEMIDX_W+1:2];

    // one strobe per semaphore, only on a write
    always_comb
    begin
        for (int i = 0; i < hsem_pkg::SEM_NUM; i++)
        begin
            sem_wr[i] = wr_en && sem_hit && (rd_idx == hsem_pkg::SEMIDX_W'(i));
        end
    end

    assign err_clr = wr_en && (addr == hsem_pkg::ERR_CLR_OFFSET);

    // --------------------
    // read select, independent of wr_en
    // --------------------
    always_comb
    begin
        if (sem_hit)
        begin
            rd_sel = hsem_pkg::RD_SEM;
        end
        else if (addr == hsem_pkg::ERR_OFFSET)
        begin
            rd_sel = hsem_pkg::RD_ERR;
        end
        else if (addr == hsem_pkg::STATUS_0_OFFSET)
        begin
            rd_sel = hsem_pkg::RD_STATUS_0;
        end
        else if (addr == hsem_pkg::STATUS_1_OFFSET)
        begin
            rd_sel = hsem_pkg::RD_STATUS_1;
        end
        else
        begin
            rd_sel = hsem_pkg::RD_NONE;   // includes the error clear address
        end
    end

endmodule

/* design/sem_cell.sv */
// one hardware semaphore, holds lock state and owner and classifies each request
module sem_cell
(
    input  logic                      hclk,
    input  logic                      hresetn,
    input  logic                      wr,
    input  logic [hsem_pkg::ID_W-1:0] req_id,
    input  logic                      req_lock,
    output hsem_pkg::sem_state_e      state,
    output logic [hsem_pkg::ID_W-1:0] owner,
    output hsem_pkg::sem_err_e        err_code
);

    logic do_lock;   // free semaphore granted to req_id
    logic do_free;   // owner gives it back
    logic is_owner;

    assign is_owner = (owner == req_id);

    // --------------------
    // request evaluation
    // --------------------
    always_comb
    begin
        do_lock  = 1'b0;
        do_free  = 1'b0;
        err_code = hsem_pkg::ERR_NONE;
        if (wr)
        begin
            if (req_lock)
            begin
                if (state == hsem_pkg::SEM_FREE)
                begin
                    do_lock = 1'b1;
                end
                else if (is_owner)
                begin
                    err_code = hsem_pkg::ERR_ALREADY_OWN;
                end
                // held by the other core, silently refused
            end
            else
            begin
                if (state == hsem_pkg::SEM_FREE)
                begin
                    err_code = hsem_pkg::ERR_ALREADY_FREE;
                end
                else if (is_owner)
                begin
                    do_free = 1'b1;
                end
                else
                begin
                    err_code = hsem_pkg::ERR_ILLEGAL_FREE;   // not ours to free
                end
            end
        end
    end

    // --------------------
    // lock state and owner
    // --------------------
    always_ff @(posedge hclk or negedge hresetn)
    begin
        if (!hresetn)
        begin
            state <= hsem_pkg::SEM_FREE;
            owner <= '0;
        end
        else if (do_lock)
        begin
            state <= hsem_pkg::SEM_TAKEN;
            owner <= req_id;
        end
        else if (do_free)
        begin
            state <= hsem_pkg::SEM_FREE;
            owner <= '0;   // free semaphores show no owner
        end
    end

endmodule

/* design/sem_report.sv */
// status masks, error register and read data mux for the semaphore block
module sem_report
(
    input  logic                          hclk,
    input  logic                          hresetn,
    input  hsem_pkg::sem_state_e          state    [0:hsem_pkg::SEM_NUM-1],
    input  logic [hsem_pkg::ID_W-1:0]     owner    [0:hsem_pkg::SEM_NUM-1],
    input  hsem_pkg::sem_err_e            err_code [0:hsem_pkg::SEM_NUM-1],
    input  logic [hsem_pkg::ID_W-1:0]     req_id,
    input  logic                          err_clr,
    input  hsem_pkg::read_sel_e           rd_sel,
    input  logic [hsem_pkg::SEMIDX_W-1:0] rd_idx,
    output logic [hsem_pkg::DATA_W-1:0]   rdata,
    output logic                          err_valid
);

    logic [hsem_pkg::SEM_NUM-1:0]       status_0;
    logic [hsem_pkg::SEM_NUM-1:0]       status_1;
    logic                               err_hit;
    logic [hsem_pkg::SEMIDX_W-1:0]      err_idx;
    hsem_pkg::sem_err_e                 err_sel;
    logic [hsem_pkg::ERR_VALID_BIT-1:0] err_info;   // {faultid, semnum, code}

    // --------------------
    // per-core ownership masks
    // --------------------
    always_comb
    begin
        for (int i = 0; i < hsem_pkg::SEM_NUM; i++)
        begin
            status_0[i] = (owner[i] == hsem_pkg::CORE_0_ID);
            status_1[i] = (owner[i] == hsem_pkg::CORE_1_ID);
        end
    end

    // pick the erroring cell, at most one per cycle
    always_comb
    begin
        err_hit = 1'b0;
        err_idx = '0;
        err_sel = hsem_pkg::ERR_NONE;
        for (int i = 0; i < hsem_pkg::SEM_NUM; i++)
        begin
            if (err_code[i] != hsem_pkg::ERR_NONE)
            begin
                err_hit = 1'b1;
                err_idx = hsem_pkg::SEMIDX_W'(i);
                err_sel = err_code[i];
            end
        end
    end

    // --------------------
    // error register
    // --------------------
    always_ff @(posedge hclk or negedge hresetn)
    begin
        if (!hresetn)
        begin
            err_valid <= 1'b0;
            err_info  <= '0;
        end
        else if (err_hit)
        begin
            err_valid <= 1'b1;
            err_info  <= {req_id, hsem_pkg::SEMNUM_W'(err_idx), err_sel};
        end
        else if (err_clr)
        begin
            err_valid <= 1'b0;   // fields kept, only valid drops
        end
    end

    // --------------------
    // read mux
    // --------------------
    always_comb
    begin
        rdata = '0;
        case (rd_sel)
            hsem_pkg::RD_SEM:
            begin
                rdata[hsem_pkg::TAKEN_BIT]                     = state[rd_idx];
                rdata[hsem_pkg::OWNER_MSB:hsem_pkg::OWNER_LSB] = owner[rd_idx];
            end
            hsem_pkg::RD_ERR:
            begin
                rdata[hsem_pkg::ERR_VALID_BIT:0] = {err_valid, err_info};
            end
            hsem_pkg::RD_STATUS_0:
            begin
                rdata[hsem_pkg::SEM_NUM-1:0] = status_0;
            end
            hsem_pkg::RD_STATUS_1:
            begin
                rdata[hsem_pkg::SEM_NUM-1:0] = status_1;
            end
            default:
            begin
                rdata = '0;   // unmapped and write-only addresses
            end
        endcase
    end

endmodule

/* design/hsem_top.sv */
// top of the hardware semaphore register block, decoder plus eight cells plus report logic
module hsem_top
(
    input  logic                        hclk,
    input  logic                        hresetn,
    input  logic [hsem_pkg::ADDR_W-1:0] addr,
    input  logic                        wr_en,
    input  logic [hsem_pkg::DATA_W-1:0] wdata,
    output logic [hsem_pkg::DATA_W-1:0] rdata,
    output logic                        err_valid
);

    logic [hsem_pkg::SEM_NUM-1:0]  sem_wr;
    logic                          err_clr;
    hsem_pkg::read_sel_e           rd_sel;
    logic [hsem_pkg::SEMIDX_W-1:0] rd_idx;
    logic [hsem_pkg::ID_W-1:0]     req_id;
    logic                          req_lock;

    hsem_pkg::sem_state_e          state    [0:hsem_pkg::SEM_NUM-1];
    logic [hsem_pkg::ID_W-1:0]     owner    [0:hsem_pkg::SEM_NUM-1];
    hsem_pkg::sem_err_e            err_code [0:hsem_pkg::SEM_NUM-1];

    // write word carries the requester id and the lock bit
    assign req_id   = wdata[hsem_pkg::OWNER_MSB:hsem_pkg::OWNER_LSB];
    assign req_lock = wdata[hsem_pkg::TAKEN_BIT];

    sem_addr_decode u_decode (
        .addr    (addr),
        .wr_en   (wr_en),
        .sem_wr  (sem_wr),
        .err_clr (err_clr),
        .rd_sel  (rd_sel),
        .rd_idx  (rd_idx)
    );

    // --------------------
    // semaphore cells
    // --------------------
    for (genvar i = 0; i < hsem_pkg::SEM_NUM; i++)
    begin : g_cell
        sem_cell u_cell (
            .hclk     (hclk),
            .hresetn  (hresetn),
            .wr       (sem_wr[i]),
            .req_id   (req_id),
            .req_lock (req_lock),
            .state    (state[i]),
            .owner    (owner[i]),
            .err_code (err_code[i])
        );
    end

    sem_report u_report (
        .hclk      (hclk),
        .hresetn   (hresetn),
        .state     (state),
        .owner     (owner),
        .err_code  (err_code),
        .req_id    (req_id),
        .err_clr   (err_clr),
        .rd_sel    (rd_sel),
        .rd_idx    (rd_idx),
        .rdata     (rdata),
        .err_valid (err_valid)
    );

endmodule

/* dv/hsem_sva.sv */
// protocol and consistency assertions for the semaphore block, bound into every hsem_top
module hsem_sva
(
    input logic                      hclk,
    input logic                      hresetn,
    input logic                      err_clr,
    input logic                      err_valid,
    input hsem_pkg::sem_state_e      state    [0:hsem_pkg::SEM_NUM-1],
    input logic [hsem_pkg::ID_W-1:0] owner    [0:hsem_pkg::SEM_NUM-1],
    input hsem_pkg::sem_err_e        err_code [0:hsem_pkg::SEM_NUM-1]
);
    timeunit 1ns;
    timeprecision 1ps;

    int unsigned                  fail_cnt = 0;   // read by the testbench at the end
    logic                         err_any;        // some cell flags an error this cycle
    logic [hsem_pkg::SEM_NUM-1:0] own_0;          // status mask bits as seen from the owners
    logic [hsem_pkg::SEM_NUM-1:0] own_1;
    logic [hsem_pkg::SEM_NUM-1:0] taken;
    logic [hsem_pkg::SEM_NUM-1:0] has_owner;

    always_comb
    begin
        err_any = 1'b0;
        for (int i = 0; i < hsem_pkg::SEM_NUM; i++)
        begin
            err_any      = err_any | (err_code[i] != hsem_pkg::ERR_NONE);
            taken[i]     = (state[i] == hsem_pkg::SEM_TAKEN);
            has_owner[i] = (owner[i] != '0);
            own_0[i]     = (owner[i] == hsem_pkg::CORE_0_ID);
            own_1[i]     = (owner[i] == hsem_pkg::CORE_1_ID);
        end
    end

    // --------------------
    // error register timing
    // --------------------
    err_follows_write: assert property (@(posedge hclk) disable iff (!hresetn)
        err_any |=> err_valid)
        else
        begin
            fail_cnt++;
            $error("err_valid did not rise one cycle after an erroring write");
        end

    no_spurious_err: assert property (@(posedge hclk) disable iff (!hresetn)
        $rose(err_valid) |-> $past(err_any))
        else
        begin
            fail_cnt++;
            $error("err_valid rose without an erroring write in the cycle before");
        end

    clear_drops_valid: assert property (@(posedge hclk) disable iff (!hresetn)
        (err_clr && !err_any) |=> !err_valid)
        else
        begin
            fail_cnt++;
            $error("err_valid still high one cycle after an error clear");
        end

    // --------------------
    // ownership consistency
    // --------------------
    // each taken semaphore sits in exactly one mask, a free one in none
    single_owner: assert property (@(posedge hclk) disable iff (!hresetn)
        ((own_0 & own_1) == '0) && ((own_0 | own_1) == taken))
        else
        begin
            fail_cnt++;
            $error("status masks disagree with the taken flags or overlap");
        end

    owner_matches_state: assert property (@(posedge hclk) disable iff (!hresetn)
        taken == has_owner)
        else
        begin
            fail_cnt++;
            $error("taken flags and owner fields disagree");
        end

endmodule

bind hsem_top hsem_sva u_sva (
    .hclk      (hclk),
    .hresetn   (hresetn),
    .err_clr   (err_clr),
    .err_valid (err_valid),
    .state     (state),
    .owner     (owner),
    .err_code  (err_code)
);

/* dv/tb_hsem.sv */
// testbench for hsem_top, directed and random semaphore traffic compared with a reference model
module tb_hsem;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RAND_OPS    = 200;
    localparam int TEST_CYCLES = 3 + 100 + RAND_OPS * 8;   // reset, directed, random
    localparam int WATCHDOG_NS = TEST_CYCLES * 10 + 1000;

    logic                        hclk;
    logic                        hresetn;
    logic [hsem_pkg::ADDR_W-1:0] addr;
    logic                        wr_en;
    logic [hsem_pkg::DATA_W-1:0] wdata;
    logic [hsem_pkg::DATA_W-1:0] rdata;
    logic                        err_valid;

    int seed    = 32'hf54b;
    int err_cnt = 0;

    // --------------------
    // reference model
    // --------------------
    logic                      m_taken [0:hsem_pkg::SEM_NUM-1];
    logic [hsem_pkg::ID_W-1:0] m_owner [0:hsem_pkg::SEM_NUM-1];
    logic                      m_err_valid;
    logic [15:0]               m_err;   // {faultid, semnum, code}

    hsem_top UUT (
        .hclk      (hclk),
        .hresetn   (hresetn),
        .addr      (addr),
        .wr_en     (wr_en),
        .wdata     (wdata),
        .rdata     (rdata),
        .err_valid (err_valid)
    );

    always #5 hclk = ~hclk;

    task automatic model_write(input int idx, input logic [7:0] id, input logic lock);
        hsem_pkg::sem_err_e code;
        code = hsem_pkg::ERR_NONE;
        if (lock && !m_taken[idx])
        begin
            m_taken[idx] = 1'b1;
            m_owner[idx] = id;
        end
        else if (lock && m_owner[idx] == id)
            code = hsem_pkg::ERR_ALREADY_OWN;
        else if (!lock && !m_taken[idx])
            code = hsem_pkg::ERR_ALREADY_FREE;
        else if (!lock && m_owner[idx] == id)
        begin
            m_taken[idx] = 1'b0;
            m_owner[idx] = '0;
        end
        else if (!lock)
            code = hsem_pkg::ERR_ILLEGAL_FREE;   // lock on a foreign one falls through
        if (code != hsem_pkg::ERR_NONE)
        begin
            m_err_valid = 1'b1;
            m_err       = {id, 5'(idx), code};
        end
    endtask

    function automatic logic [31:0] expect_read(input logic [7:0] a);
        logic [31:0] v;
        logic [7:0]  want;
        v = '0;
        if (a < 8'(hsem_pkg::SEM_NUM * 4) && a[1:0] == 2'b00)
        begin
            v[0]    = m_taken[a[4:2]];
            v[15:8] = m_owner[a[4:2]];
        end
        else if (a == hsem_pkg::ERR_OFFSET)
            v[hsem_pkg::ERR_VALID_BIT:0] = {m_err_valid, m_err};
        else if (a == hsem_pkg::STATUS_0_OFFSET || a == hsem_pkg::STATUS_1_OFFSET)
        begin
            want = (a == hsem_pkg::STATUS_0_OFFSET) ? hsem_pkg::CORE_0_ID : hsem_pkg::CORE_1_ID;
            for (int i = 0; i < hsem_pkg::SEM_NUM; i++)
                v[i] = m_taken[i] && (m_owner[i] == want);
        end
        return v;
    endfunction

    task automatic bus_write(input logic [7:0] a, input logic [31:0] d);
        @(posedge hclk);
        addr  <= a;
        wdata <= d;
        wr_en <= 1'b1;
        @(posedge hclk);
        wr_en <= 1'b0;   // single cycle strobe
    endtask

    task automatic sem_access(input int idx, input logic [7:0] id, input logic lock);
        model_write(idx, id, lock);
        bus_write(8'(idx * 4), {16'h0, id, 7'h0, lock});
    endtask

    task automatic read_check(input string name, input logic [7:0] a);
        logic [31:0] exp;
        exp = expect_read(a);
        @(posedge hclk);
        addr <= a;
        @(negedge hclk);   // rdata settled
        if (rdata !== exp)
        begin
            err_cnt++;
            $display("mismatch %s: addr 0x%02h expected 0x%08h actual 0x%08h",
                     name, a, exp, rdata);
        end
        if (err_valid !== m_err_valid)
        begin
            err_cnt++;
            $display("mismatch %s err_valid: expected %0b actual %0b", name, m_err_valid, err_valid);
        end
    endtask

    initial
    begin
        int         idx;
        logic [7:0] id;
        hclk        = 1'b0;
        hresetn     = 1'b0;
        addr        = '0;
        wr_en       = 1'b0;
        wdata       = '0;
        m_err_valid = 1'b0;
        m_err       = '0;
        for (int i = 0; i < hsem_pkg::SEM_NUM; i++)
        begin
            m_taken[i] = 1'b0;
            m_owner[i] = '0;
        end
        repeat (3) @(posedge hclk);
        hresetn <= 1'b1;

        // -------------------- reset state
        for (int i = 0; i < hsem_pkg::SEM_NUM; i++)
            read_check("reset sem", 8'(i * 4));
        read_check("reset status 0", hsem_pkg::STATUS_0_OFFSET);
        read_check("reset status 1", hsem_pkg::STATUS_1_OFFSET);
        read_check("reset error", hsem_pkg::ERR_OFFSET);

        // -------------------- directed lock, free and error cases
        sem_access(3, hsem_pkg::CORE_0_ID, 1'b1);
        read_check("lock free", 8'h0C);
        sem_access(3, hsem_pkg::CORE_1_ID, 1'b1);   // refused, no error
        read_check("refused lock", 8'h0C);
        read_check("status 0 after lock", hsem_pkg::STATUS_0_OFFSET);
        sem_access(3, hsem_pkg::CORE_1_ID, 1'b0);
        read_check("illegal free", hsem_pkg::ERR_OFFSET);
        read_check("still taken", 8'h0C);
        sem_access(3, hsem_pkg::CORE_0_ID, 1'b0);
        read_check("owner free", 8'h0C);
        read_check("status 0 after free", hsem_pkg::STATUS_0_OFFSET);
        sem_access(3, hsem_pkg::CORE_0_ID, 1'b0);
        read_check("already free", hsem_pkg::ERR_OFFSET);
        sem_access(5, hsem_pkg::CORE_1_ID, 1'b1);
        sem_access(5, hsem_pkg::CORE_1_ID, 1'b1);
        read_check("already own", hsem_pkg::ERR_OFFSET);
        read_check("status 1", hsem_pkg::STATUS_1_OFFSET);
        bus_write(hsem_pkg::ERR_CLR_OFFSET, '0);
        m_err_valid = 1'b0;
        read_check("error clear", hsem_pkg::ERR_OFFSET);
        read_check("unmapped", 8'h3C);

        // -------------------- random traffic from both cores
        for (int n = 0; n < RAND_OPS; n++)
        begin
            idx = $unsigned($random(seed)) % hsem_pkg::SEM_NUM;
            id  = ($random(seed) & 1) ? hsem_pkg::CORE_1_ID : hsem_pkg::CORE_0_ID;
            sem_access(idx, id, 1'($random(seed) & 1));
            read_check("random sem", 8'(idx * 4));
            read_check("random status 0", hsem_pkg::STATUS_0_OFFSET);
            read_check("random status 1", hsem_pkg::STATUS_1_OFFSET);
        end
        read_check("random error", hsem_pkg::ERR_OFFSET);
        @(posedge hclk);

        $display("errors: %0d mismatches, %0d assertion failures", err_cnt, UUT.u_sva.fail_cnt);
        if (err_cnt == 0 && UUT.u_sva.fail_cnt == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

    // watchdog
    initial
    begin
        #(WATCHDOG_NS * 1ns);
        $display("timeout: stimulus did not finish within %0d ns", WATCHDOG_NS);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

/* hsem_top.f */
design/hsem_pkg.sv
design/sem_addr_decode.sv
design/sem_cell.sv
design/sem_report.sv
design/hsem_top.sv
dv/hsem_sva.sv
dv/tb_hsem.sv
